//--- source/decode_pkg.sv
`default_nettype none

package decode_pkg;

    typedef enum logic [6:0] {
        lw      = 7'b0000011,
        sw      = 7'b0100011,
        flw     = 7'b0000111,
        fsw     = 7'b0100111,
        cin_int = 7'b0010100,   // custom input port read
        out     = 7'b0010101,   // custom output port write
        auipc   = 7'b0010111,
        lui     = 7'b0110111,
        op      = 7'b0110011,   // r-type integer
        op_imm  = 7'b0010011,
        branch  = 7'b1100011,
        jalr    = 7'b1100111,
        jal     = 7'b1101111,
        system  = 7'b1110011,   // csrrw
        fmadd   = 7'b1000011,
        fmsub   = 7'b1000111,
        fnmsub  = 7'b1001011,
        fnmadd  = 7'b1001111,
        op_fp   = 7'b1010011
    } opcode_e;

    typedef enum logic [2:0] {
        alu, mem, pc4, csr, imm, int_to_fp, fpu, input_port
    } result_src_e;

    typedef enum logic [2:0] {
        i_type, s_type, b_type, j_type, i_uimm, u_type
    } imm_src_e;

    typedef enum logic [1:0] {
        add, sub, funct, pc_add
    } alu_op_e;

    // msb first, same order as the legacy control word
    typedef struct packed {
        logic        reg_write;
        imm_src_e    imm_src;
        logic        alu_src;
        logic        mem_read;
        logic        mem_write;
        result_src_e result_src;
        logic        branch;
        alu_op_e     alu_op;
        logic        jump;
        logic        c_reg_write;   // csr write
        logic        out_issued;
        logic        in_issued;
        logic        fpu_dispatch;
        logic        fpu_reg_write;
        logic        write_src;
        logic        s_fpu;         // single precision op
    } ctrl_t;

    localparam int CTRL_W = $bits(ctrl_t);

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        ctrl_t       ctrl;
        logic [31:0] imm;
        logic        illegal;
    } dec_pkt_t;

    typedef enum logic [1:0] {
        enables       = 2'd0,   // bit 0 fpu_en, bit 1 io_en
        illegal_count = 2'd1
    } cfg_addr_e;

endpackage

`default_nettype wire

//--- source/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
    input  logic [31:0]         instr,
    output decode_pkg::ctrl_t   ctrl,
    output logic                known,
    output logic                fp_op,
    output logic                io_op
);

    decode_pkg::opcode_e             opcode;
    logic [2:0]                      funct3;
    logic [3:0]                      funct7_3_6;
    logic [decode_pkg::CTRL_W-1:0]   controls;

    assign opcode     = decode_pkg::opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_3_6 = instr[31:28];   // funct7 bits 6..3

    assign ctrl = decode_pkg::ctrl_t'(controls);

    // field order: reg imm alusrc memr memw res br aluop j csr out in fpud fpurw wsrc sfpu
    always_comb begin
        controls = '0;
        known    = 1'b1;
        case (opcode)
            decode_pkg::lw:      controls = 21'b1_000_1_1_0_001_0_00_0_0_0_0_0_0_0_0;
            decode_pkg::sw:      controls = 21'b0_001_1_0_1_000_0_00_0_0_0_0_0_0_0_0;
            decode_pkg::cin_int: controls = 21'b1_000_0_0_0_111_0_00_0_0_0_1_0_0_0_0;
            decode_pkg::out:     controls = 21'b0_000_0_0_0_000_0_00_0_0_1_0_0_0_0_0;
            decode_pkg::auipc:   controls = 21'b1_101_1_0_0_000_0_11_0_0_0_0_0_0_0_0;
            decode_pkg::op:      controls = 21'b1_000_0_0_0_000_0_10_0_0_0_0_0_0_0_0;
            decode_pkg::lui:     controls = 21'b1_101_0_0_0_100_0_00_0_0_0_0_0_0_0_0;
            decode_pkg::branch:  controls = 21'b0_010_0_0_0_000_1_01_0_0_0_0_0_0_0_0;
            decode_pkg::op_imm: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    controls = 21'b1_100_1_0_0_000_0_10_0_0_0_0_0_0_0_0;   // shifts, uimm
                end else begin
                    controls = 21'b1_000_1_0_0_000_0_10_0_0_0_0_0_0_0_0;
                end
            end
            decode_pkg::jalr:    controls = 21'b1_000_1_0_0_010_0_10_1_0_0_0_0_0_0_0;
            decode_pkg::jal:     controls = 21'b1_011_0_0_0_010_0_00_1_0_0_0_0_0_0_0;
            decode_pkg::system:  controls = 21'b1_000_0_0_0_011_0_00_0_1_0_0_0_0_0_0;
            decode_pkg::fmadd,
            decode_pkg::fmsub,
            decode_pkg::fnmsub,
            decode_pkg::fnmadd:  controls = 21'b0_000_0_0_0_110_0_00_0_0_0_0_1_1_0_1;
            decode_pkg::op_fp: begin
                casez (funct7_3_6)
                    4'b0???: controls = 21'b0_000_0_0_0_110_0_00_0_0_0_0_1_1_0_1;  // arith
                    4'b1010: controls = 21'b1_000_0_0_0_110_0_00_0_0_0_0_1_0_0_1;  // compares
                    4'b1100: controls = 21'b1_000_0_0_0_110_0_00_0_0_0_0_1_0_0_1;  // fcvt.w.s
                    4'b1101: controls = 21'b0_000_0_0_0_110_0_00_0_0_0_0_1_1_0_0;  // fcvt.s.w
                    4'b1110: begin
                        if (funct3 == 3'b001) begin
                            controls = 21'b1_000_0_0_0_110_0_00_0_0_0_0_1_0_0_1;   // fclass
                        end else if (funct3 == 3'b000) begin
                            controls = 21'b1_000_0_0_0_011_0_00_0_0_0_0_0_0_0_1;   // fmv.x.w
                        end else begin
                            known = 1'b0;
                        end
                    end
                    4'b1111: controls = 21'b0_000_0_0_0_101_0_00_0_0_0_0_0_1_0_0;  // fmv.w.x
                    default: known = 1'b0;
                endcase
            end
            decode_pkg::flw:     controls = 21'b0_000_1_1_0_001_0_00_0_0_0_0_0_1_0_0;
            decode_pkg::fsw:     controls = 21'b0_001_1_0_1_110_0_00_0_0_0_0_0_0_1_1;
            default:             known = 1'b0;
        endcase
    end

    // group membership, independent of known
    always_comb begin
        case (opcode)
            decode_pkg::fmadd, decode_pkg::fmsub, decode_pkg::fnmsub, decode_pkg::fnmadd,
            decode_pkg::op_fp, decode_pkg::flw, decode_pkg::fsw: fp_op = 1'b1;
            default: fp_op = 1'b0;
        endcase
    end

    assign io_op = (opcode == decode_pkg::cin_int) || (opcode == decode_pkg::out);

endmodule

`default_nettype wire

//--- source/imm_extend.sv
`timescale 1ns/1ps
`default_nettype none

module imm_extend (
    input  logic [31:0]           instr,
    input  decode_pkg::imm_src_e  imm_src,
    output logic [31:0]           imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            decode_pkg::i_type: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            decode_pkg::s_type: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            decode_pkg::b_type: begin
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            decode_pkg::j_type: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            decode_pkg::i_uimm: begin
                imm = {27'b0, instr[24:20]};   // shamt, zero extended
            end
            decode_pkg::u_type: begin
                imm = {instr[31:12], 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/decode_config.sv
`timescale 1ns/1ps
`default_nettype none

module decode_config (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   cfg_write,
    input  decode_pkg::cfg_addr_e  cfg_addr,
    input  logic [31:0]            cfg_wdata,
    output logic [31:0]            cfg_rdata,
    input  logic                   illegal_seen,
    output logic                   fpu_en,
    output logic                   io_en
);

    logic [15:0] illegal_cnt;
    logic        clr_cnt;

    assign clr_cnt = cfg_write && (cfg_addr == decode_pkg::illegal_count);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fpu_en <= 1'b1;
            io_en  <= 1'b1;
        end else if (cfg_write && cfg_addr == decode_pkg::enables) begin
            fpu_en <= cfg_wdata[0];
            io_en  <= cfg_wdata[1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            illegal_cnt <= '0;
        end else if (clr_cnt) begin
            illegal_cnt <= '0;   // clear beats increment
        end else if (illegal_seen && illegal_cnt != 16'hffff) begin
            illegal_cnt <= illegal_cnt + 16'd1;   // saturates
        end
    end

    always_comb begin
        case (cfg_addr)
            decode_pkg::enables:       cfg_rdata = {30'b0, io_en, fpu_en};
            decode_pkg::illegal_count: cfg_rdata = {16'b0, illegal_cnt};
            default:                   cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  decode_pkg::fetch_pkt_t  in_pkt,
    output logic                    in_credit,
    output logic                    out_valid,
    output decode_pkg::dec_pkt_t    out_pkt,
    input  logic                    out_credit,
    input  logic                    fpu_en,
    input  logic                    io_en,
    output logic                    illegal_seen
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    decode_pkg::fetch_pkt_t  buf_mem [IN_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        fill;
    logic [CRD_W-1:0]        credits;
    logic                    pop;

    decode_pkg::fetch_pkt_t  head;
    decode_pkg::ctrl_t       dec_ctrl;
    decode_pkg::ctrl_t       ctrl_gated;
    logic [31:0]             imm;
    logic                    known;
    logic                    fp_op;
    logic                    io_op;
    logic                    illegal;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(IN_DEPTH - 1)) begin
            nxt = '0;   // depth need not be a power of two
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign pop       = (fill != '0) && (credits != '0);
    assign in_credit = pop;   // one credit back per entry leaving the buffer
    assign head      = buf_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            buf_mem[wr_ptr] <= in_pkt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= CRD_W'(OUT_CREDITS);
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill    <= fill + CNT_W'(in_valid) - CNT_W'(pop);
            credits <= credits + CRD_W'(out_credit) - CRD_W'(pop);
        end
    end

    main_decoder u_main_decoder (
        .instr (head.instr),
        .ctrl  (dec_ctrl),
        .known (known),
        .fp_op (fp_op),
        .io_op (io_op)
    );

    imm_extend u_imm_extend (
        .instr   (head.instr),
        .imm_src (dec_ctrl.imm_src),
        .imm     (imm)
    );

    assign illegal = !known || (fp_op && !fpu_en) || (io_op && !io_en);

    always_comb begin
        ctrl_gated = dec_ctrl;
        if (illegal) begin   // nothing may write or dispatch
            ctrl_gated.reg_write     = 1'b0;
            ctrl_gated.mem_read      = 1'b0;
            ctrl_gated.mem_write     = 1'b0;
            ctrl_gated.branch        = 1'b0;
            ctrl_gated.jump          = 1'b0;
            ctrl_gated.c_reg_write   = 1'b0;
            ctrl_gated.out_issued    = 1'b0;
            ctrl_gated.in_issued     = 1'b0;
            ctrl_gated.fpu_dispatch  = 1'b0;
            ctrl_gated.fpu_reg_write = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_pkt.pc      <= head.pc;
            out_pkt.instr   <= head.instr;
            out_pkt.ctrl    <= ctrl_gated;
            out_pkt.imm     <= imm;
            out_pkt.illegal <= illegal;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid    <= 1'b0;
            illegal_seen <= 1'b0;
        end else begin
            out_valid    <= pop;
            illegal_seen <= pop && illegal;
        end
    end

    // upstream must never send without a credit
    assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> (fill < CNT_W'(IN_DEPTH)))
        else $error("decode_stage: write into full buffer");

    // extra credits from downstream, or a wrap below zero, land above the limit
    assert property (@(posedge clk) disable iff (!arst_n)
        credits <= CRD_W'(OUT_CREDITS))
        else $error("decode_stage: out credits out of range");

endmodule

`default_nettype wire

//--- source/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  decode_pkg::fetch_pkt_t  in_pkt,
    output logic                    in_credit,
    output logic                    out_valid,
    output decode_pkg::dec_pkt_t    out_pkt,
    input  logic                    out_credit,
    input  logic                    cfg_write,
    input  decode_pkg::cfg_addr_e   cfg_addr,
    input  logic [31:0]             cfg_wdata,
    output logic [31:0]             cfg_rdata
);

    logic fpu_en;
    logic io_en;
    logic illegal_seen;

    decode_stage #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_decode_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_pkt       (in_pkt),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_pkt      (out_pkt),
        .out_credit   (out_credit),
        .fpu_en       (fpu_en),
        .io_en        (io_en),
        .illegal_seen (illegal_seen)
    );

    decode_config u_decode_config (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .illegal_seen (illegal_seen),
        .fpu_en       (fpu_en),
        .io_en        (io_en)
    );

endmodule

`default_nettype wire

//--- tb/tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_MIXED     = 96;
    localparam int N_NO_FPU    = 32;
    localparam int N_NO_IO     = 32;
    localparam int N_HOLD      = IN_DEPTH + OUT_CREDITS;   // fills buffer and credits
    localparam int TIMEOUT     = 40 * (N_MIXED + N_NO_FPU + N_NO_IO + N_HOLD) + 200;

    logic                    clk;
    logic                    arst_n;
    logic                    in_valid;
    decode_pkg::fetch_pkt_t  in_pkt;
    logic                    in_credit;
    logic                    out_valid;
    decode_pkg::dec_pkt_t    out_pkt;
    logic                    out_credit;
    logic                    cfg_write;
    decode_pkg::cfg_addr_e   cfg_addr;
    logic [31:0]             cfg_wdata;
    logic [31:0]             cfg_rdata;

    logic [31:0]             lfsr;
    logic [31:0]             next_pc;
    decode_pkg::dec_pkt_t    exp_q[$];
    string                   test_name;
    logic                    hold_credits;   // downstream withholds out_credit
    logic                    fpu_on;         // mirror of the enables register
    logic                    io_on;
    int                      errors;
    int                      cycles;
    int                      send_limit;
    int                      accepted;
    int                      up_credits;
    int                      credit_pulses;
    int                      held;           // packets downstream has not credited yet
    int                      received;
    int                      flagged;

    decode_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt),
        .out_credit (out_credit),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // {fixed-bit mask, fixed-bit value}, the rest of the word is random
    function automatic logic [63:0] pick_template(input logic [4:0] idx);
        case (idx)
            5'd0:  return {32'h0000007f, 32'h00000003};   // lw
            5'd1:  return {32'h0000007f, 32'h00000023};   // sw
            5'd2:  return {32'h0000007f, 32'h00000007};   // flw
            5'd3:  return {32'h0000007f, 32'h00000027};   // fsw
            5'd4:  return {32'h0000007f, 32'h00000014};   // cin_int
            5'd5:  return {32'h0000007f, 32'h00000015};   // out
            5'd6:  return {32'h0000007f, 32'h00000017};   // auipc
            5'd7:  return {32'h0000007f, 32'h00000037};   // lui
            5'd8:  return {32'h0000007f, 32'h00000033};   // r-type
            5'd9:  return {32'h0000007f, 32'h00000013};   // op_imm, any funct3
            5'd10: return {32'h0000707f, 32'h00001013};   // slli
            5'd11: return {32'h0000707f, 32'h00005013};   // srli / srai
            5'd12: return {32'h0000007f, 32'h00000063};   // branch
            5'd13: return {32'h0000007f, 32'h00000067};   // jalr
            5'd14: return {32'h0000007f, 32'h0000006f};   // jal
            5'd15: return {32'h0000007f, 32'h00000073};   // csrrw
            5'd16: return {32'h0000007f, 32'h00000043};
            5'd17: return {32'h0000007f, 32'h00000047};
            5'd18: return {32'h0000007f, 32'h0000004b};
            5'd19: return {32'h0000007f, 32'h0000004f};
            5'd20: return {32'h8000007f, 32'h00000053};   // fp arithmetic
            5'd21: return {32'hf000007f, 32'ha0000053};   // fp compares
            5'd22: return {32'hf000007f, 32'hc0000053};   // fcvt.w.s
            5'd23: return {32'hf000007f, 32'hd0000053};   // fcvt.s.w
            5'd24: return {32'hf000707f, 32'he0001053};   // fclass
            5'd25: return {32'hf000707f, 32'he0000053};   // fmv.x.w
            5'd26: return {32'hf000007f, 32'hf0000053};   // fmv.w.x
            5'd27: return {32'hf000007f, 32'h90000053};   // unlisted op_fp
            5'd28: return {32'hf000707f, 32'he0007053};   // unlisted op_fp
            5'd29: return {32'h0000007f, 32'h0000000b};   // unknown opcodes
            5'd30: return {32'h0000007f, 32'h0000007f};
            default: return {32'h0000007f, 32'h00000000};
        endcase
    endfunction

    // reference control table, don't-cares as zero
    function automatic decode_pkg::ctrl_t ref_ctrl(input logic [31:0] ins, output logic known);
        decode_pkg::ctrl_t c;
        logic [3:0]        f7;
        logic [2:0]        f3;
        c = '0;
        known = 1'b1;
        f7 = ins[31:28];
        f3 = ins[14:12];
        case (ins[6:0])
            decode_pkg::lw, decode_pkg::flw: begin
                c.reg_write = (ins[6:0] == decode_pkg::lw);
                c.fpu_reg_write = (ins[6:0] == decode_pkg::flw);
                c.alu_src = 1'b1;
                c.mem_read = 1'b1;
                c.result_src = decode_pkg::mem;
            end
            decode_pkg::sw, decode_pkg::fsw: begin
                c.imm_src = decode_pkg::s_type;
                c.alu_src = 1'b1;
                c.mem_write = 1'b1;
                if (ins[6:0] == decode_pkg::fsw) begin
                    c.result_src = decode_pkg::fpu;
                    c.write_src = 1'b1;
                    c.s_fpu = 1'b1;
                end
            end
            decode_pkg::cin_int: begin
                c.reg_write = 1'b1;
                c.result_src = decode_pkg::input_port;
                c.in_issued = 1'b1;
            end
            decode_pkg::out: c.out_issued = 1'b1;
            decode_pkg::auipc, decode_pkg::lui: begin
                c.reg_write = 1'b1;
                c.imm_src = decode_pkg::u_type;
                c.alu_src = (ins[6:0] == decode_pkg::auipc);
                c.alu_op = (ins[6:0] == decode_pkg::auipc) ? decode_pkg::pc_add : decode_pkg::add;
                c.result_src = (ins[6:0] == decode_pkg::lui) ? decode_pkg::imm : decode_pkg::alu;
            end
            decode_pkg::op, decode_pkg::op_imm, decode_pkg::jalr: begin
                c.reg_write = 1'b1;
                c.alu_op = decode_pkg::funct;
                c.alu_src = (ins[6:0] != decode_pkg::op);
                if (ins[6:0] == decode_pkg::op_imm && (f3 == 3'b001 || f3 == 3'b101)) begin
                    c.imm_src = decode_pkg::i_uimm;   // shift amount
                end
                if (ins[6:0] == decode_pkg::jalr) begin
                    c.result_src = decode_pkg::pc4;
                    c.jump = 1'b1;
                end
            end
            decode_pkg::branch: begin
                c.imm_src = decode_pkg::b_type;
                c.branch = 1'b1;
                c.alu_op = decode_pkg::sub;
            end
            decode_pkg::jal: begin
                c.reg_write = 1'b1;
                c.imm_src = decode_pkg::j_type;
                c.result_src = decode_pkg::pc4;
                c.jump = 1'b1;
            end
            decode_pkg::system: begin
                c.reg_write = 1'b1;
                c.result_src = decode_pkg::csr;
                c.c_reg_write = 1'b1;
            end
            decode_pkg::fmadd, decode_pkg::fmsub, decode_pkg::fnmsub, decode_pkg::fnmadd,
            decode_pkg::op_fp: begin
                c.result_src = decode_pkg::fpu;
                if (ins[6:0] != decode_pkg::op_fp || !f7[3]) begin
                    c.fpu_dispatch = 1'b1;
                    c.fpu_reg_write = 1'b1;
                    c.s_fpu = 1'b1;
                end else if (f7 == 4'b1010 || f7 == 4'b1100 || (f7 == 4'b1110 && f3 == 3'b001)) begin
                    c.reg_write = 1'b1;
                    c.fpu_dispatch = 1'b1;
                    c.s_fpu = 1'b1;
                end else if (f7 == 4'b1101) begin
                    c.fpu_dispatch = 1'b1;
                    c.fpu_reg_write = 1'b1;
                end else if (f7 == 4'b1110 && f3 == 3'b000) begin
                    c.reg_write = 1'b1;
                    c.result_src = decode_pkg::csr;   // fmv.x.w
                    c.s_fpu = 1'b1;
                end else if (f7 == 4'b1111) begin
                    c.result_src = decode_pkg::int_to_fp;
                    c.fpu_reg_write = 1'b1;
                end else begin
                    c = '0;
                    known = 1'b0;
                end
            end
            default: known = 1'b0;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] ins, input decode_pkg::imm_src_e src);
        case (src)
            decode_pkg::i_type: return {{20{ins[31]}}, ins[31:20]};
            decode_pkg::s_type: return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            decode_pkg::b_type: return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            decode_pkg::j_type: return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            decode_pkg::i_uimm: return {27'b0, ins[24:20]};
            decode_pkg::u_type: return {ins[31:12], 12'b0};
            default: return '0;
        endcase
    endfunction

    function automatic decode_pkg::dec_pkt_t expect_pkt(input logic [31:0] pc, input logic [31:0] ins);
        decode_pkg::dec_pkt_t p;
        logic                 known;
        logic                 fp;
        logic                 io;
        p.pc = pc;
        p.instr = ins;
        p.ctrl = ref_ctrl(ins, known);
        p.imm = ref_imm(ins, p.ctrl.imm_src);
        fp = ins[6:0] inside {7'h07, 7'h27, 7'h43, 7'h47, 7'h4b, 7'h4f, 7'h53};
        io = ins[6:0] inside {7'h14, 7'h15};
        p.illegal = !known || (fp && !fpu_on) || (io && !io_on);
        if (p.illegal) begin   // no write, no dispatch
            p.ctrl.reg_write = 1'b0;
            p.ctrl.mem_read = 1'b0;
            p.ctrl.mem_write = 1'b0;
            p.ctrl.branch = 1'b0;
            p.ctrl.jump = 1'b0;
            p.ctrl.c_reg_write = 1'b0;
            p.ctrl.out_issued = 1'b0;
            p.ctrl.in_issued = 1'b0;
            p.ctrl.fpu_dispatch = 1'b0;
            p.ctrl.fpu_reg_write = 1'b0;
        end
        return p;
    endfunction

    task automatic check_value(input string field, input logic [63:0] want, input logic [63:0] got);
        assert (want === got) else begin
            errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", test_name, field, want, got);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR in %s: %s", test_name, msg);
    endtask

    task automatic finish_run();
        $display("errors: %0d, packets checked: %0d", errors, received);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // downstream monitor, downstream credit return and upstream sender
    always @(posedge clk) begin
        decode_pkg::dec_pkt_t want;
        logic [31:0]          r;
        logic [63:0]          t;
        logic [31:0]          ins;
        if (arst_n) begin
            if (out_valid) begin
                received++;
                held++;
                if (exp_q.size() == 0) begin
                    report_error("a packet came out with none outstanding");
                end else begin
                    want = exp_q.pop_front();
                    check_value("pc", want.pc, out_pkt.pc);
                    check_value("instr", want.instr, out_pkt.instr);
                    check_value("ctrl", want.ctrl, out_pkt.ctrl);
                    check_value("imm", want.imm, out_pkt.imm);
                    check_value("illegal", want.illegal, out_pkt.illegal);
                end
                assert (held <= OUT_CREDITS) else report_error("more packets sent than credits");
            end
            out_credit <= 1'b0;
            if (held > 0 && !hold_credits) begin
                draw(1, r);
                if (r[0]) begin
                    out_credit <= 1'b1;
                    held--;
                end
            end
            if (in_credit) begin
                credit_pulses++;
                up_credits++;
            end
            assert (credit_pulses <= accepted) else report_error("in_credit pulsed too often");
            in_valid <= 1'b0;
            if (accepted < send_limit && up_credits > 0) begin
                draw(2, r);
                if (r[1:0] != 2'b00) begin   // random gaps
                    draw(5, r);
                    t = pick_template(r[4:0]);
                    draw(32, r);
                    ins = (r & ~t[63:32]) | t[31:0];
                    in_valid <= 1'b1;
                    in_pkt.pc <= next_pc;
                    in_pkt.instr <= ins;
                    want = expect_pkt(next_pc, ins);
                    exp_q.push_back(want);
                    if (want.illegal) begin
                        flagged++;
                    end
                    next_pc += 32'd4;
                    up_credits--;
                    accepted++;
                end
            end
        end
    end

    task automatic wait_idle();
        @(posedge clk);
        while (accepted < send_limit || exp_q.size() != 0 || held != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);   // counter lags out_valid
    endtask

    task automatic write_cfg(input decode_pkg::cfg_addr_e a, input logic [31:0] d);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr <= a;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_write <= 1'b0;
    endtask

    task automatic read_cfg(input decode_pkg::cfg_addr_e a, output logic [31:0] d);
        @(posedge clk);
        cfg_addr <= a;
        @(posedge clk);
        d = cfg_rdata;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        report_error("timeout, the run did not finish in time");
        finish_run();
    end

    initial begin
        logic [31:0] rd;
        int          mark;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_pkt = '0;
        out_credit = 1'b0;
        cfg_write = 1'b0;
        cfg_addr = decode_pkg::enables;
        cfg_wdata = '0;
        lfsr = 32'hd0c3_0d3a;
        next_pc = 32'h0000_1000;
        test_name = "reset";
        hold_credits = 1'b0;
        fpu_on = 1'b1;
        io_on = 1'b1;
        errors = 0;
        send_limit = 0;
        accepted = 0;
        up_credits = IN_DEPTH;
        credit_pulses = 0;
        held = 0;
        received = 0;
        flagged = 0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        read_cfg(decode_pkg::enables, rd);
        check_value("enables", 32'h3, rd);
        read_cfg(decode_pkg::illegal_count, rd);
        check_value("illegal_count", 32'h0, rd);

        test_name <= "control decode";
        send_limit <= N_MIXED;
        wait_idle();
        test_name <= "illegal count";
        read_cfg(decode_pkg::illegal_count, rd);
        check_value("illegal_count", flagged, rd);
        write_cfg(decode_pkg::illegal_count, 32'h0);
        read_cfg(decode_pkg::illegal_count, rd);
        check_value("illegal_count cleared", 32'h0, rd);
        mark = flagged;

        write_cfg(decode_pkg::enables, 32'h2);
        fpu_on <= 1'b0;
        test_name <= "fpu disabled";
        send_limit <= N_MIXED + N_NO_FPU;
        wait_idle();
        write_cfg(decode_pkg::enables, 32'h1);
        fpu_on <= 1'b1;
        io_on <= 1'b0;
        test_name <= "io disabled";
        send_limit <= N_MIXED + N_NO_FPU + N_NO_IO;
        wait_idle();
        write_cfg(decode_pkg::enables, 32'h3);
        io_on <= 1'b1;
        test_name <= "illegal count";
        read_cfg(decode_pkg::illegal_count, rd);
        check_value("illegal_count", flagged - mark, rd);

        test_name <= "out credits";
        hold_credits <= 1'b1;
        mark = received;
        send_limit <= N_MIXED + N_NO_FPU + N_NO_IO + N_HOLD;
        repeat (40) @(posedge clk);   // long enough to fill everything
        check_value("packets while held", OUT_CREDITS, received - mark);
        check_value("upstream credits while held", 0, up_credits);
        hold_credits <= 1'b0;
        wait_idle();
        check_value("packets after release", N_HOLD, received - mark);

        test_name <= "in credits";
        @(posedge clk);
        check_value("upstream credits", IN_DEPTH, up_credits);
        check_value("credit pulses", accepted, credit_pulses);
        finish_run();
    end

endmodule

`default_nettype wire

//--- all.f
source/decode_pkg.sv
source/main_decoder.sv
source/imm_extend.sv
source/decode_config.sv
source/decode_stage.sv
source/decode_top.sv
tb/tb_decode_top.sv
